//--- rtl/sd_share_pkg.sv
//*********************************************************************
// shared definitions of the sd card sharing unit
//  - controller channel enum, in grant priority order
//  - arbiter state enum
//  - per-channel vector type
//  - idle levels of the card lines
//*********************************************************************
`default_nettype none

package sd_share_pkg;

   //******************************************************************
   // channels
   //******************************************************************
   localparam int N_CHAN = 6;                 // disk controllers on the card

   // value is the bit index in every channel vector
   typedef enum logic [2:0] {
      CH_RK = 3'd0,                           // rk11, highest priority
      CH_DW = 3'd1,                           // dw winchester
      CH_DM = 3'd2,                           // rk611
      CH_DB = 3'd3,                           // rh70
      CH_DX = 3'd4,                           // rx01 floppy
      CH_MY = 3'd5                            // my floppy, lowest priority
   } sd_chan_e;

   typedef logic [N_CHAN-1:0] sd_vec_t;       // one bit per controller

   //******************************************************************
   // arbiter
   //******************************************************************
   typedef enum logic [0:0] {
      ST_IDLE  = 1'b0,                        // card free, scanning requests
      ST_OWNED = 1'b1                         // card held by one controller
   } sd_state_e;

   //******************************************************************
   // card line levels while in reset
   //******************************************************************
   localparam logic CS_IDLE   = 1'b1;         // card deselected
   localparam logic MOSI_IDLE = 1'b1;         // spi data line idles high
   localparam logic SCLK_IDLE = 1'b0;         // clock parked low

endpackage

`default_nettype wire

//--- rtl/sd_req_filter.sv
//*********************************************************************
// request filter of the sd card sharing unit
//  - register chain per controller request
//  - active-low disk activity lamps
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_req_filter #(
   parameter int SYNC_STAGES = 2              // depth of the filter chain
) (
   input  logic                  sdclock,     // sd card clock
   input  logic                  rst_i,       // sync reset, active high
   input  sd_share_pkg::sd_vec_t req_i,       // raw requests from controllers
   output sd_share_pkg::sd_vec_t req_filt_o,  // requests after the chain
   output sd_share_pkg::sd_vec_t lamp_o       // activity lamps, low = busy
);

   //******************************************************************
   // filter chain
   //******************************************************************
   sd_share_pkg::sd_vec_t chain_q [SYNC_STAGES]; // stage 0 takes the raw request

   always_ff @(posedge sdclock) begin
      if (rst_i) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            chain_q[i] <= '0;                 // no request seen yet
         end
      end else begin
         chain_q[0] <= req_i;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            chain_q[i] <= chain_q[i-1];       // shift one stage per clock
         end
      end
   end

   // arbiter judges grant and release on the last stage
   assign req_filt_o = chain_q[SYNC_STAGES-1];

   //******************************************************************
   // disk lamps
   //******************************************************************
   // lamps light on the raw request, so a short access still blinks
   assign lamp_o = ~req_i;                    // led pulls low while requesting

endmodule

`default_nettype wire

//--- rtl/sd_grant_fsm.sv
//*********************************************************************
// sd card arbiter
//  - fixed priority scan over the controller requests
//  - owner tracking, no preemption
//  - fast channel granted on its raw request
//  - protocol assertions on the grant vector
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_grant_fsm #(
   parameter sd_share_pkg::sd_chan_e FAST_CHANNEL = sd_share_pkg::CH_RK
) (
   input  logic                  sdclock,     // sd card clock
   input  logic                  rst_i,       // sync reset, active high
   input  sd_share_pkg::sd_vec_t req_i,       // raw requests, fast channel only
   input  sd_share_pkg::sd_vec_t req_filt_i,  // filtered requests
   output sd_share_pkg::sd_vec_t grant_o      // one-hot or zero
);

   sd_share_pkg::sd_state_e state_q;          // idle or owned
   sd_share_pkg::sd_chan_e  owner_q;          // current card owner
   sd_share_pkg::sd_vec_t   grant_q;          // registered grant vector
   sd_share_pkg::sd_vec_t   elig;             // channels that may win now
   sd_share_pkg::sd_chan_e  pick_ch;          // winner of the scan
   logic                    pick_vld;         // some channel is eligible

   //******************************************************************
   // priority scan
   //******************************************************************
   always_comb begin
      elig               = req_filt_i;
      elig[FAST_CHANNEL] = req_i[FAST_CHANNEL]; // fast channel skips the filter
      pick_vld           = 1'b0;
      pick_ch            = sd_share_pkg::CH_RK;
      // walk downwards so the lowest index is the last one written
      for (int i = sd_share_pkg::N_CHAN - 1; i >= 0; i--) begin
         if (elig[i]) begin
            pick_vld = 1'b1;
            pick_ch  = sd_share_pkg::sd_chan_e'(3'(i));
         end
      end
   end

   //******************************************************************
   // state machine
   //******************************************************************
   always_ff @(posedge sdclock) begin
      if (rst_i) begin
         state_q <= sd_share_pkg::ST_IDLE;
         owner_q <= sd_share_pkg::CH_RK;
         grant_q <= '0;                       // card free after reset
      end else begin
         case (state_q)
            sd_share_pkg::ST_IDLE: begin
               if (pick_vld) begin
                  state_q <= sd_share_pkg::ST_OWNED;
                  owner_q <= pick_ch;         // remember who holds the card
                  grant_q <= sd_share_pkg::sd_vec_t'(1) << pick_ch;
               end
            end
            sd_share_pkg::ST_OWNED: begin
               // release waits for the filtered request, even on the fast channel
               if (!req_filt_i[owner_q]) begin
                  state_q <= sd_share_pkg::ST_IDLE;
                  grant_q <= '0;              // at least one free cycle follows
               end
            end
            default: begin
               state_q <= sd_share_pkg::ST_IDLE;
               grant_q <= '0;
            end
         endcase
      end
   end

   assign grant_o = grant_q;

   //******************************************************************
   // assertions
   //******************************************************************
   // never two controllers on the card at once
   a_grant_onehot: assert property (
      @(posedge sdclock) disable iff (rst_i)
      $onehot0(grant_o)
   ) else $error("sd arbiter: more than one grant bit set");

   // a new grant needs a request seen on the deciding edge
   a_grant_has_req: assert property (
      @(posedge sdclock) disable iff (rst_i)
      (grant_o & ~$past(grant_o) & ~$past(req_i | req_filt_i)) == '0
   ) else $error("sd arbiter: grant rose without a request");

   // handover always passes through a free card
   a_no_direct_handover: assert property (
      @(posedge sdclock) disable iff (rst_i)
      ($past(grant_o) != '0 && grant_o != $past(grant_o)) |-> grant_o == '0
   ) else $error("sd arbiter: card passed straight to another owner");

endmodule

`default_nettype wire

//--- rtl/sd_card_mux.sv
//*********************************************************************
// sd card line mux
//  - owner's cs, mosi and sclk onto the card
//  - default channel's lines while the card is free
//  - idle levels during reset
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_card_mux #(
   parameter sd_share_pkg::sd_chan_e DEFAULT_CHANNEL = sd_share_pkg::CH_RK
) (
   input  logic                  sdclock,     // assertion clock only
   input  logic                  rst_i,       // sync reset, active high
   input  sd_share_pkg::sd_vec_t grant_i,     // one-hot owner or zero
   input  sd_share_pkg::sd_vec_t chan_cs_i,   // cs from each controller
   input  sd_share_pkg::sd_vec_t chan_mosi_i, // mosi from each controller
   input  sd_share_pkg::sd_vec_t chan_sclk_i, // sclk from each controller
   output logic                  card_cs_o,   // to the card
   output logic                  card_mosi_o,
   output logic                  card_sclk_o
);

   //******************************************************************
   // line select
   //******************************************************************
   always_comb begin
      if (rst_i) begin
         card_cs_o   = sd_share_pkg::CS_IDLE;     // card parked
         card_mosi_o = sd_share_pkg::MOSI_IDLE;
         card_sclk_o = sd_share_pkg::SCLK_IDLE;
      end else if (grant_i == '0) begin
         // free card listens to the controller that runs sdspi master
         card_cs_o   = chan_cs_i[DEFAULT_CHANNEL];
         card_mosi_o = chan_mosi_i[DEFAULT_CHANNEL];
         card_sclk_o = chan_sclk_i[DEFAULT_CHANNEL];
      end else begin
         card_cs_o   = |(grant_i & chan_cs_i);    // grant is one-hot
         card_mosi_o = |(grant_i & chan_mosi_i);
         card_sclk_o = |(grant_i & chan_sclk_i);
      end
   end

   //******************************************************************
   // assertions
   //******************************************************************
   for (genvar g = 0; g < sd_share_pkg::N_CHAN; g++) begin : g_cs_chk
      // owner's chip select reaches the card unchanged
      a_owner_cs: assert property (
         @(posedge sdclock) disable iff (rst_i)
         grant_i[g] |-> card_cs_o == chan_cs_i[g]
      ) else $error("sd mux: card cs differs from owner %0d", g);
   end

endmodule

`default_nettype wire

//--- rtl/sd_share_top.sv
//*********************************************************************
// sd card sharing unit, top level
//  - request filter and activity lamps
//  - priority arbiter
//  - card line mux
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_share_top #(
   parameter int                     SYNC_STAGES     = 2,  // filter depth
   parameter sd_share_pkg::sd_chan_e FAST_CHANNEL    = sd_share_pkg::CH_RK,
   parameter sd_share_pkg::sd_chan_e DEFAULT_CHANNEL = sd_share_pkg::CH_RK
) (
   input  logic                  sdclock,     // sd card clock
   input  logic                  rst_i,       // sync reset, active high
   input  sd_share_pkg::sd_vec_t req_i,       // card requests, levels
   input  sd_share_pkg::sd_vec_t chan_cs_i,   // controller spi lines
   input  sd_share_pkg::sd_vec_t chan_mosi_i,
   input  sd_share_pkg::sd_vec_t chan_sclk_i,
   output sd_share_pkg::sd_vec_t grant_o,     // card owner, one-hot or zero
   output sd_share_pkg::sd_vec_t lamp_o,      // disk lamps, active low
   output logic                  card_cs_o,   // sd card lines
   output logic                  card_mosi_o,
   output logic                  card_sclk_o
);

   sd_share_pkg::sd_vec_t req_filt;           // filtered requests
   sd_share_pkg::sd_vec_t grant;              // arbiter grant

   //******************************************************************
   // request filter
   //******************************************************************
   sd_req_filter #(
      .SYNC_STAGES (SYNC_STAGES)
   ) i_filter (
      .sdclock    (sdclock),
      .rst_i      (rst_i),
      .req_i      (req_i),
      .req_filt_o (req_filt),
      .lamp_o     (lamp_o)
   );

   //******************************************************************
   // arbiter
   //******************************************************************
   sd_grant_fsm #(
      .FAST_CHANNEL (FAST_CHANNEL)
   ) i_arb (
      .sdclock    (sdclock),
      .rst_i      (rst_i),
      .req_i      (req_i),                    // raw path for the fast channel
      .req_filt_i (req_filt),
      .grant_o    (grant)
   );

   assign grant_o = grant;

   //******************************************************************
   // card mux
   //******************************************************************
   sd_card_mux #(
      .DEFAULT_CHANNEL (DEFAULT_CHANNEL)
   ) i_mux (
      .sdclock     (sdclock),
      .rst_i       (rst_i),
      .grant_i     (grant),
      .chan_cs_i   (chan_cs_i),
      .chan_mosi_i (chan_mosi_i),
      .chan_sclk_i (chan_sclk_i),
      .card_cs_o   (card_cs_o),
      .card_mosi_o (card_mosi_o),
      .card_sclk_o (card_sclk_o)
   );

endmodule

`default_nettype wire

//--- tests/sd_share_tb.sv
//*********************************************************************
// testbench of the sd card sharing unit
//  - cases file reader, request phases and latency checks
//  - random controller spi lines
//  - reference model of the filter chain and the arbiter
//  - per-cycle checks of grant, card lines and lamps
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module sd_share_tb;

   localparam int         CLK_PERIOD  = 20;   // ns
   localparam int         SYNC_STAGES = 2;    // filter depth given to the dut
   localparam int         FAST_IDX    = 0;    // rk is the fast channel
   localparam int         DEFAULT_IDX = 0;    // rk drives a free card
   localparam int         MAX_CASES   = 64;
   localparam logic [2:0] NONE        = 3'd7; // owner code of a free card

   logic                  sdclock;
   logic                  rst_i;
   sd_share_pkg::sd_vec_t req_i;
   sd_share_pkg::sd_vec_t chan_cs_i;
   sd_share_pkg::sd_vec_t chan_mosi_i;
   sd_share_pkg::sd_vec_t chan_sclk_i;
   sd_share_pkg::sd_vec_t grant_o;
   sd_share_pkg::sd_vec_t lamp_o;
   logic                  card_cs_o;
   logic                  card_mosi_o;
   logic                  card_sclk_o;

   integer                seed   = 57;       // $random seed
   int                    limit  = 50;       // grows by every hold length
   int                    cycles = 0;
   logic [23:0]           case_mem [MAX_CASES]; // mask, hold, owner per phase
   sd_share_pkg::sd_vec_t hist [SYNC_STAGES];  // model of the filter chain
   logic [2:0]            m_owner = NONE;      // model owner

   sd_share_top #(
      .SYNC_STAGES     (SYNC_STAGES),
      .FAST_CHANNEL    (sd_share_pkg::CH_RK),
      .DEFAULT_CHANNEL (sd_share_pkg::CH_RK)
   ) i_dut (
      .sdclock     (sdclock),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .chan_cs_i   (chan_cs_i),
      .chan_mosi_i (chan_mosi_i),
      .chan_sclk_i (chan_sclk_i),
      .grant_o     (grant_o),
      .lamp_o      (lamp_o),
      .card_cs_o   (card_cs_o),
      .card_mosi_o (card_mosi_o),
      .card_sclk_o (card_sclk_o)
   );

   //******************************************************************
   // error handling and helpers
   //******************************************************************
   task automatic fail_now(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string what);
      fail_now($sformatf("Mismatch at %0t ns: %s", $time, what));
   endtask

   // lowest set bit wins with the fast channel on its raw request
   function automatic logic [2:0] first_eligible(input sd_share_pkg::sd_vec_t filt,
                                                 input sd_share_pkg::sd_vec_t raw);
      sd_share_pkg::sd_vec_t cand;
      logic [2:0]            win;
      cand           = filt;
      cand[FAST_IDX] = raw[FAST_IDX];
      win            = NONE;
      for (int i = 0; i < sd_share_pkg::N_CHAN; i++) begin
         if (cand[i] && win == NONE) begin
            win = 3'(i);
         end
      end
      return win;
   endfunction

   function automatic logic [2:0] owner_of(input sd_share_pkg::sd_vec_t g);
      return first_eligible(g, g);             // grant has at most one bit
   endfunction

   //******************************************************************
   // clock, timeout, controller lines
   //******************************************************************
   initial begin
      sdclock = 1'b0;
      forever #(CLK_PERIOD / 2) sdclock = ~sdclock;
   end

   always @(posedge sdclock) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         fail_now($sformatf("Timeout: run did not end within %0d cycles", limit));
      end
   end

   always @(posedge sdclock) begin : drive_spi_lines
      logic [31:0] rnd;
      rnd = $random(seed);
      chan_cs_i   <= rnd[5:0];               // fresh lines every cycle
      chan_mosi_i <= rnd[13:8];
      chan_sclk_i <= rnd[21:16];
   end

   //******************************************************************
   // reference model sampled on the same edge as the dut
   //******************************************************************
   always @(posedge sdclock) begin
      if (rst_i) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            hist[i] <= '0;
         end
         m_owner <= NONE;
      end else begin
         hist[0] <= req_i;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            hist[i] <= hist[i-1];
         end
         if (m_owner == NONE) begin
            m_owner <= first_eligible(hist[SYNC_STAGES-1], req_i);
         end else if (!hist[SYNC_STAGES-1][m_owner]) begin
            m_owner <= NONE;                   // owner let go so the card is free
         end
      end
   end

   // outputs are compared half a cycle after the edge
   always @(negedge sdclock) begin : check_cycle
      sd_share_pkg::sd_vec_t exp_grant;
      logic [2:0]            exp_line;       // cs, mosi, sclk
      exp_grant = (m_owner == NONE) ? '0 : (sd_share_pkg::sd_vec_t'(1) << m_owner);
      if (rst_i) begin
         exp_line = 3'b110;                  // parked card with cs and mosi high
      end else if (m_owner == NONE) begin
         exp_line = {chan_cs_i[DEFAULT_IDX], chan_mosi_i[DEFAULT_IDX],
                     chan_sclk_i[DEFAULT_IDX]};
      end else begin
         exp_line = {chan_cs_i[m_owner], chan_mosi_i[m_owner], chan_sclk_i[m_owner]};
      end
      assert (grant_o == exp_grant) else
         report_mismatch($sformatf("grant_o %b, expected %b", grant_o, exp_grant));
      assert ({card_cs_o, card_mosi_o, card_sclk_o} == exp_line) else
         report_mismatch($sformatf("card lines %b%b%b, expected %b",
                                   card_cs_o, card_mosi_o, card_sclk_o, exp_line));
      assert (lamp_o == ~req_i) else
         report_mismatch($sformatf("lamp_o %b, requests %b", lamp_o, req_i));
   end

   //******************************************************************
   // phases from the cases file
   //******************************************************************
   initial begin
      int                    n_cases;
      int                    hold;
      int                    first_rise;
      logic [2:0]            exp_owner;
      sd_share_pkg::sd_vec_t mask;
      sd_share_pkg::sd_vec_t prev_mask;
      rst_i       = 1'b1;
      req_i       = '0;
      chan_cs_i   = '0;
      chan_mosi_i = '0;
      chan_sclk_i = '0;
      $readmemh("tests/sd_share_cases.txt", case_mem);
      n_cases = 0;
      while (n_cases < MAX_CASES && case_mem[n_cases][23:16] != 8'hff) begin
         limit += int'(case_mem[n_cases][15:8]);
         n_cases++;
      end
      if (n_cases == 0 || n_cases == MAX_CASES) begin
         fail_now("cases file is missing, empty or has no end marker");
      end
      repeat (4) @(posedge sdclock);
      rst_i     <= 1'b0;
      prev_mask = '0;
      for (int p = 0; p < n_cases; p++) begin
         mask      = case_mem[p][16 +: sd_share_pkg::N_CHAN];
         hold      = int'(case_mem[p][15:8]);
         exp_owner = case_mem[p][2:0];
         @(posedge sdclock);
         req_i      <= mask;
         first_rise = 0;
         for (int n = 1; n < hold; n++) begin
            @(posedge sdclock);
            @(negedge sdclock);
            if (first_rise == 0 && grant_o != '0) begin
               first_rise = n;                 // edges since the mask went out
            end
         end
         // lone request on a free card
         if (prev_mask == '0 && $onehot(mask)) begin
            assert (first_rise == (mask[FAST_IDX] ? 1 : SYNC_STAGES + 1)) else
               report_mismatch($sformatf("phase %0d grant after %0d edges", p, first_rise));
         end
         assert (owner_of(grant_o) == exp_owner) else
            report_mismatch($sformatf("phase %0d owner %0d, expected %0d",
                                      p, owner_of(grant_o), exp_owner));
         prev_mask = mask;
      end
      repeat (2) @(posedge sdclock);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/sd_share_cases.txt
// one phase per line, hex: request mask _ hold cycles _ owner at end of hold (07 = none)
// bit 0 rk (fast) .. bit 5 my; ff ends the list
00_08_07
02_08_01
00_08_07
01_08_00
00_08_07
2c_08_02
28_0a_03
2a_08_03
22_0a_01
23_08_01
21_0a_00
20_0a_05
00_08_07
10_08_04
00_08_07
08_08_03
00_08_07
20_08_05
00_06_07
3f_08_00
3e_0a_01
3c_0a_02
38_0a_03
30_0a_04
20_0a_05
00_08_07
11_08_00
10_0a_04
00_08_07
ff_00_00

//--- list.f
rtl/sd_share_pkg.sv
rtl/sd_req_filter.sv
rtl/sd_grant_fsm.sv
rtl/sd_card_mux.sv
rtl/sd_share_top.sv
tests/sd_share_tb.sv

//--- Makefile
# Verilator build of the sd card sharing unit and its testbench

TB_TOP  = sd_share_tb
RTL_TOP = sd_share_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only rtl/sd_share_pkg.sv rtl/sd_req_filter.sv rtl/sd_grant_fsm.sv \
		rtl/sd_card_mux.sv rtl/sd_share_top.sv --top-module $(RTL_TOP)
	verilator --lint-only --timing -f list.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TB_TOP) \
		-Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
